/* logic/flash_player.sv */
`timescale 1ns/10ps

module flash_player (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  playing,
  input  logic                  backward,
  input  logic                  restart,
  input  logic                  sample_strobe,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  output ipod_pkg::audio_t      audio_data,
  output logic                  audio_valid
);

  logic [1:0]            state;
  logic                  restart_pend;
  logic                  do_restart;
  logic                  take_strobe;
  logic                  accept_data;
  logic                  emit_second;
  ipod_pkg::flash_addr_t next_addr;
  ipod_pkg::flash_addr_t restart_addr;
  ipod_pkg::sample_t     second_sample;

  // A restart is only applied where no read is in flight
  assign do_restart  = restart || restart_pend;
  assign take_strobe = sample_strobe && playing;
  assign accept_data = (state == ipod_pkg::st_wait_data) && flash_readdatavalid;
  assign emit_second = (state == ipod_pkg::st_second_half) && !do_restart && take_strobe;

  assign restart_addr = backward ? ipod_pkg::audio_last_addr : '0;

  // Word step with wrap at both ends of the audio region
  always_comb
  begin
    if (backward)
      next_addr = (flash_address == '0) ? ipod_pkg::audio_last_addr : flash_address - 23'd1;
    else
      next_addr = (flash_address == ipod_pkg::audio_last_addr) ? '0 : flash_address + 23'd1;
  end

  // ==================================================
  // Read FSM
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state         <= ipod_pkg::st_idle;
      flash_read    <= 1'b0;
      flash_address <= '0;
      audio_valid   <= 1'b0;
      restart_pend  <= 1'b0;
    end
    else
    begin
      audio_valid <= 1'b0;
      if (restart)
        restart_pend <= 1'b1;
      case (state)
        ipod_pkg::st_idle:
        begin
          if (do_restart)
          begin
            flash_address <= restart_addr;
            restart_pend  <= 1'b0;
          end
          else if (take_strobe)
          begin
            flash_read <= 1'b1;
            state      <= ipod_pkg::st_request;
          end
        end
        ipod_pkg::st_request:
        begin
          // Address and read are held while the flash stalls
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= ipod_pkg::st_wait_data;
          end
        end
        ipod_pkg::st_wait_data:
        begin
          if (flash_readdatavalid)
          begin
            audio_valid <= 1'b1;
            state       <= ipod_pkg::st_second_half;
          end
        end
        ipod_pkg::st_second_half:
        begin
          if (do_restart)
          begin
            flash_address <= restart_addr;
            restart_pend  <= 1'b0;
            state         <= ipod_pkg::st_idle;
          end
          else if (take_strobe)
          begin
            audio_valid   <= 1'b1;
            flash_address <= next_addr;
            state         <= ipod_pkg::st_idle;
          end
        end
        default:
          state <= ipod_pkg::st_idle;
      endcase
    end
  end

  // ==================================================
  // Sample split
  // ==================================================
  // Forward plays the low half first, backward the high half
  always_ff @(posedge CLK_50M)
  begin
    if (accept_data)
    begin
      if (backward)
      begin
        audio_data    <= flash_readdata[31:24];
        second_sample <= flash_readdata[15:0];
      end
      else
      begin
        audio_data    <= flash_readdata[15:8];
        second_sample <= flash_readdata[31:16];
      end
    end
    else if (emit_second)
      audio_data <= second_sample[15:8];
  end

endmodule

/* logic/hex_display.sv */
`timescale 1ns/10ps

module hex_display (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  ipod_pkg::div_count_t div_count,
  output ipod_pkg::seg_t       hex0,
  output ipod_pkg::seg_t       hex1,
  output ipod_pkg::seg_t       hex2,
  output ipod_pkg::seg_t       hex3,
  output ipod_pkg::seg_t       hex4,
  output ipod_pkg::seg_t       hex5
);

  ipod_pkg::div_count_t                count_reg;
  logic [ipod_pkg::num_digits*4-1:0] display_value;

  // Active low, bit 0 is segment a
  function automatic ipod_pkg::seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'b1000000;
      4'h1: seg_decode = 7'b1111001;
      4'h2: seg_decode = 7'b0100100;
      4'h3: seg_decode = 7'b0110000;
      4'h4: seg_decode = 7'b0011001;
      4'h5: seg_decode = 7'b0010010;
      4'h6: seg_decode = 7'b0000010;
      4'h7: seg_decode = 7'b1111000;
      4'h8: seg_decode = 7'b0000000;
      4'h9: seg_decode = 7'b0010000;
      4'hA: seg_decode = 7'b0001000;
      4'hB: seg_decode = 7'b0000011;
      4'hC: seg_decode = 7'b1000110;
      4'hD: seg_decode = 7'b0100001;
      4'hE: seg_decode = 7'b0000110;
      default: seg_decode = 7'b0001110;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      count_reg <= ipod_pkg::div_default;
    else
      count_reg <= div_count;
  end

  // Top two digits stay at zero
  assign display_value = {8'h00, count_reg};

  assign hex0 = seg_decode(display_value[3:0]);
  assign hex1 = seg_decode(display_value[7:4]);
  assign hex2 = seg_decode(display_value[11:8]);
  assign hex3 = seg_decode(display_value[15:12]);
  assign hex4 = seg_decode(display_value[19:16]);
  assign hex5 = seg_decode(display_value[23:20]);

endmodule

/* logic/ipod_pkg.sv */
package ipod_pkg;

  // ==================================================
  // Data widths
  // ==================================================
  typedef logic [7:0]  scan_code_t;
  typedef logic [7:0]  audio_t;
  typedef logic [15:0] sample_t;
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;
  typedef logic [15:0] div_count_t;
  typedef logic [6:0]  seg_t;

  // ==================================================
  // PS/2 set 2 scan codes
  // ==================================================
  localparam scan_code_t scan_play     = 8'h24;  // E
  localparam scan_code_t scan_pause    = 8'h23;  // D
  localparam scan_code_t scan_backward = 8'h32;  // B
  localparam scan_code_t scan_forward  = 8'h2B;  // F
  localparam scan_code_t scan_restart  = 8'h2D;  // R
  localparam scan_code_t scan_break    = 8'hF0;

  // ==================================================
  // Sample divider limits
  // ==================================================
  // 50 MHz / 2272 gives roughly 22 kHz
  localparam div_count_t div_default = 16'd2272;
  localparam div_count_t div_step    = 16'd100;
  localparam div_count_t div_min     = 16'd272;
  localparam div_count_t div_max     = 16'd60000;

  // Audio region in flash
  localparam flash_addr_t audio_last_addr = 23'h07FFFF;

  // Seven-segment digits on the board
  localparam int num_digits = 6;

  // Flash player FSM states
  localparam logic [1:0] st_idle        = 2'd0;
  localparam logic [1:0] st_request     = 2'd1;
  localparam logic [1:0] st_wait_data   = 2'd2;
  localparam logic [1:0] st_second_half = 2'd3;

endpackage

/* logic/ipod_top.sv */
`timescale 1ns/10ps

module ipod_top (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  ps2_clk,
  input  logic                  ps2_data,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  output ipod_pkg::audio_t      audio_data,
  output logic                  audio_valid,
  output ipod_pkg::seg_t        hex0,
  output ipod_pkg::seg_t        hex1,
  output ipod_pkg::seg_t        hex2,
  output ipod_pkg::seg_t        hex3,
  output ipod_pkg::seg_t        hex4,
  output ipod_pkg::seg_t        hex5
);

  ipod_pkg::scan_code_t scan_code;
  logic                 scan_ready;
  logic                 playing;
  logic                 backward;
  logic                 restart;
  ipod_pkg::div_count_t div_count;
  logic                 sample_strobe;

  // ==================================================
  // Keyboard input
  // ==================================================
  ps2_keyboard_rx u_kbd_rx (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .scan_code  (scan_code),
    .scan_ready (scan_ready)
  );

  play_command_decode u_cmd_decode (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .scan_code  (scan_code),
    .scan_ready (scan_ready),
    .playing    (playing),
    .backward   (backward),
    .restart    (restart)
  );

  // ==================================================
  // Sample timing and flash playback
  // ==================================================
  speed_control u_speed (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .div_count     (div_count),
    .sample_strobe (sample_strobe)
  );

  flash_player u_player (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .playing             (playing),
    .backward            (backward),
    .restart             (restart),
    .sample_strobe       (sample_strobe),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .audio_data          (audio_data),
    .audio_valid         (audio_valid)
  );

  // Divider count shown in hex
  hex_display u_hex (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .div_count (div_count),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .hex4      (hex4),
    .hex5      (hex5)
  );

endmodule

/* logic/play_command_decode.sv */
`timescale 1ns/10ps

module play_command_decode (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  ipod_pkg::scan_code_t scan_code,
  input  logic                 scan_ready,
  output logic                 playing,
  output logic                 backward,
  output logic                 restart
);

  // Set by a break prefix, eats the key code that follows
  logic skip_next;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      playing   <= 1'b0;
      backward  <= 1'b0;
      restart   <= 1'b0;
      skip_next <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (scan_ready)
      begin
        if (skip_next)
          skip_next <= 1'b0;
        else if (scan_code == ipod_pkg::scan_break)
          skip_next <= 1'b1;
        else
        begin
          case (scan_code)
            ipod_pkg::scan_play:
              playing <= 1'b1;
            ipod_pkg::scan_pause:
              playing <= 1'b0;
            ipod_pkg::scan_backward:
              backward <= 1'b1;
            ipod_pkg::scan_forward:
              backward <= 1'b0;
            ipod_pkg::scan_restart:
              restart <= 1'b1;
            default:
              // Other keys are ignored
              restart <= 1'b0;
          endcase
        end
      end
    end
  end

endmodule

/* logic/ps2_keyboard_rx.sv */
`timescale 1ns/10ps

module ps2_keyboard_rx (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  logic                 ps2_clk,
  input  logic                 ps2_data,
  output ipod_pkg::scan_code_t scan_code,
  output logic                 scan_ready
);

  logic                 clk_meta;
  logic                 clk_sync;
  logic                 clk_prev;
  logic                 data_meta;
  logic                 data_sync;
  logic                 clk_fall;
  logic [3:0]           bit_count;
  ipod_pkg::scan_code_t shift_reg;

  // ==================================================
  // Synchronizers and falling edge detect
  // ==================================================
  // Keyboard clock idles high, so reset to 1 avoids a false edge
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      clk_meta <= 1'b1;
      clk_sync <= 1'b1;
      clk_prev <= 1'b1;
    end
    else
    begin
      clk_meta <= ps2_clk;
      clk_sync <= clk_meta;
      clk_prev <= clk_sync;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    data_meta <= ps2_data;
    data_sync <= data_meta;
  end

  assign clk_fall = clk_prev & ~clk_sync;

  // ==================================================
  // Frame counter
  // ==================================================
  // Bit 0 start, 1..8 data, 9 parity, 10 stop
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      bit_count  <= 4'd0;
      scan_ready <= 1'b0;
    end
    else
    begin
      scan_ready <= 1'b0;
      if (clk_fall)
      begin
        if (bit_count == 4'd0)
        begin
          // Only a low start bit opens a frame
          if (!data_sync)
            bit_count <= 4'd1;
        end
        else if (bit_count == 4'd10)
        begin
          bit_count  <= 4'd0;
          scan_ready <= 1'b1;
        end
        else
          bit_count <= bit_count + 4'd1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge CLK_50M)
  begin
    if (clk_fall && (bit_count >= 4'd1) && (bit_count <= 4'd8))
      shift_reg <= {data_sync, shift_reg[7:1]};
    if (clk_fall && (bit_count == 4'd10))
      scan_code <= shift_reg;
  end

endmodule

/* logic/speed_control.sv */
`timescale 1ns/10ps

module speed_control (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  logic                 speed_up,
  input  logic                 speed_down,
  input  logic                 speed_reset,
  output ipod_pkg::div_count_t div_count,
  output logic                 sample_strobe
);

  // Bit 0 up, bit 1 down, bit 2 reset
  logic [2:0]           btn_meta;
  logic [2:0]           btn_sync;
  logic [2:0]           btn_prev;
  logic [2:0]           btn_pulse;
  ipod_pkg::div_count_t strobe_count;

  // ==================================================
  // Button sync and rising edge pulses
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      btn_meta  <= 3'b000;
      btn_sync  <= 3'b000;
      btn_prev  <= 3'b000;
      btn_pulse <= 3'b000;
    end
    else
    begin
      btn_meta  <= {speed_reset, speed_down, speed_up};
      btn_sync  <= btn_meta;
      btn_prev  <= btn_sync;
      btn_pulse <= btn_sync & ~btn_prev;
    end
  end

  // ==================================================
  // Divider count
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      div_count <= ipod_pkg::div_default;
    else if (btn_pulse[2])
      div_count <= ipod_pkg::div_default;
    else if (btn_pulse[0])
    begin
      // Faster playback means fewer clocks per sample
      if (div_count < ipod_pkg::div_min + ipod_pkg::div_step)
        div_count <= ipod_pkg::div_min;
      else
        div_count <= div_count - ipod_pkg::div_step;
    end
    else if (btn_pulse[1])
    begin
      if (div_count > ipod_pkg::div_max - ipod_pkg::div_step)
        div_count <= ipod_pkg::div_max;
      else
        div_count <= div_count + ipod_pkg::div_step;
    end
  end

  // ==================================================
  // Sample strobe
  // ==================================================
  // New div_count is picked up only when the current period ends
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      strobe_count  <= ipod_pkg::div_default;
      sample_strobe <= 1'b0;
    end
    else if (strobe_count <= 16'd1)
    begin
      strobe_count  <= div_count;
      sample_strobe <= 1'b1;
    end
    else
    begin
      strobe_count  <= strobe_count - 16'd1;
      sample_strobe <= 1'b0;
    end
  end

endmodule

/* tb.f */
logic/ipod_pkg.sv
logic/ps2_keyboard_rx.sv
logic/play_command_decode.sv
logic/speed_control.sv
logic/flash_player.sv
logic/hex_display.sv
logic/ipod_top.sv
verif/ipod_checker.sv
verif/tb_ipod.sv

/* verif/ipod_checker.sv */
`timescale 1ns/10ps

module ipod_checker (
  input logic                  CLK_50M,
  input logic                  rst,
  input logic                  flash_read,
  input logic                  flash_waitrequest,
  input ipod_pkg::flash_addr_t flash_address,
  input logic                  audio_valid,
  input logic                  sample_strobe
);

  int unsigned assert_errors = 0;

  // A stalled request keeps its read and address
  stall_holds_request: assert property (
    @(posedge CLK_50M) disable iff (rst)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
  else
  begin
    $error("flash request changed while waitrequest was high");
    assert_errors++;
  end

  // Sample output never overlaps a pending read
  no_audio_during_read: assert property (
    @(posedge CLK_50M) disable iff (rst)
    !(audio_valid && flash_read))
  else
  begin
    $error("audio_valid and flash_read were high together");
    assert_errors++;
  end

  strobe_single_cycle: assert property (
    @(posedge CLK_50M) disable iff (rst)
    sample_strobe |=> !sample_strobe)
  else
  begin
    $error("sample_strobe stayed high for more than one cycle");
    assert_errors++;
  end

endmodule

bind flash_player ipod_checker u_checker (
  .CLK_50M           (CLK_50M),
  .rst               (rst),
  .flash_read        (flash_read),
  .flash_waitrequest (flash_waitrequest),
  .flash_address     (flash_address),
  .audio_valid       (audio_valid),
  .sample_strobe     (sample_strobe)
);

/* verif/tb_ipod.sv */
`timescale 1ns/10ps

module tb_ipod;

  // 10 us half period gives a 20 us keyboard clock
  localparam int ps2_half_period = 500;
  localparam int btn_up          = 0;
  localparam int btn_down        = 1;
  localparam int btn_reset       = 2;

  logic                  CLK_50M;
  logic                  rst;
  logic                  ps2_clk;
  logic                  ps2_data;
  logic                  speed_up;
  logic                  speed_down;
  logic                  speed_reset;
  logic                  flash_waitrequest;
  ipod_pkg::flash_word_t flash_readdata;
  logic                  flash_readdatavalid;
  logic                  flash_read;
  ipod_pkg::flash_addr_t flash_address;
  ipod_pkg::audio_t      audio_data;
  logic                  audio_valid;
  ipod_pkg::seg_t        hex0;
  ipod_pkg::seg_t        hex1;
  ipod_pkg::seg_t        hex2;
  ipod_pkg::seg_t        hex3;
  ipod_pkg::seg_t        hex4;
  ipod_pkg::seg_t        hex5;

  ipod_pkg::flash_addr_t accepted_addrs[$];
  ipod_pkg::audio_t      audio_log[$];
  longint                strobe_times[$];
  longint                cycle_count = 0;
  int                    error_count = 0;

  ipod_top DUT (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .ps2_clk             (ps2_clk),
    .ps2_data            (ps2_data),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .audio_data          (audio_data),
    .audio_valid         (audio_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==================================================
  // Flash model and monitors
  // ==================================================
  // Word holds the address low half below its inverse
  initial
  begin : flash_model
    int unsigned           stall;
    int unsigned           latency;
    ipod_pkg::flash_addr_t addr;
    void'($urandom(32'hc031f227));
    forever
    begin
      @(posedge CLK_50M);
      if (!rst && flash_read)
      begin
        stall = $urandom_range(2, 0);
        repeat (stall) @(posedge CLK_50M);
        flash_waitrequest <= 1'b0;
        @(posedge CLK_50M);
        addr = flash_address;
        accepted_addrs.push_back(addr);
        flash_waitrequest <= 1'b1;
        latency = $urandom_range(4, 1);
        repeat (latency) @(posedge CLK_50M);
        flash_readdata      <= {~addr[15:0], addr[15:0]};
        flash_readdatavalid <= 1'b1;
        @(posedge CLK_50M);
        flash_readdatavalid <= 1'b0;
      end
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle_count = cycle_count + 1;
    if (!rst && audio_valid)
      audio_log.push_back(audio_data);
    if (!rst && DUT.sample_strobe)
      strobe_times.push_back(cycle_count);
  end

  // ==================================================
  // Compare tasks and expected values
  // ==================================================
  task automatic compare_audio(input string name, input ipod_pkg::audio_t got,
                               input ipod_pkg::audio_t exp);
    if (got !== exp)
    begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_address(input string name, input ipod_pkg::flash_addr_t got,
                                 input ipod_pkg::flash_addr_t exp);
    if (got !== exp)
    begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_segments(input string name, input ipod_pkg::seg_t got,
                                  input ipod_pkg::seg_t exp);
    if (got !== exp)
    begin
      $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_count(input string name, input ipod_pkg::div_count_t got,
                               input ipod_pkg::div_count_t exp);
    if (got !== exp)
    begin
      $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      error_count++;
    end
  endtask

  function automatic ipod_pkg::audio_t model_byte(input ipod_pkg::flash_addr_t addr,
                                                  input bit inverse_half);
    ipod_pkg::sample_t half;
    half = inverse_half ? ~addr[15:0] : addr[15:0];
    return half[15:8];
  endfunction

  function automatic ipod_pkg::flash_addr_t prev_word(input ipod_pkg::flash_addr_t addr);
    return (addr == '0) ? ipod_pkg::audio_last_addr : addr - 23'd1;
  endfunction

  // Lit segments as gfedcba, inverted for the active-low pins
  function automatic ipod_pkg::seg_t expected_segments(input logic [3:0] digit);
    logic [6:0] lit;
    case (digit)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  task automatic check_display(input ipod_pkg::div_count_t value);
    logic [23:0] digits;
    digits = {8'h00, value};
    compare_segments("hex0", hex0, expected_segments(digits[3:0]));
    compare_segments("hex1", hex1, expected_segments(digits[7:4]));
    compare_segments("hex2", hex2, expected_segments(digits[11:8]));
    compare_segments("hex3", hex3, expected_segments(digits[15:12]));
    compare_segments("hex4", hex4, expected_segments(digits[19:16]));
    compare_segments("hex5", hex5, expected_segments(digits[23:20]));
  endtask

  // Slot is the word's position in the log with two samples per word
  task automatic check_word(input int slot, input ipod_pkg::flash_addr_t addr,
                            input bit reverse);
    compare_address($sformatf("flash_address[%0d]", slot), accepted_addrs[slot], addr);
    compare_audio($sformatf("audio_data[%0d]", 2 * slot), audio_log[2 * slot],
                  model_byte(addr, reverse));
    compare_audio($sformatf("audio_data[%0d]", 2 * slot + 1), audio_log[2 * slot + 1],
                  model_byte(addr, !reverse));
  endtask

  // ==================================================
  // Stimulus and bounded waits
  // ==================================================
  task automatic send_key(input ipod_pkg::scan_code_t code);
    logic [10:0] frame;
    frame = {1'b1, ~^code, code, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      ps2_data <= frame[i];
      repeat (ps2_half_period) @(posedge CLK_50M);
      ps2_clk <= 1'b0;
      repeat (ps2_half_period) @(posedge CLK_50M);
      ps2_clk <= 1'b1;
    end
    ps2_data <= 1'b1;
    repeat (ps2_half_period) @(posedge CLK_50M);
  endtask

  task automatic set_button(input int which, input logic level);
    case (which)
      btn_up:   speed_up <= level;
      btn_down: speed_down <= level;
      default:  speed_reset <= level;
    endcase
  endtask

  // Count settles four cycles after the edge and the display one later
  task automatic press_button(input int which);
    set_button(which, 1'b1);
    repeat (8) @(posedge CLK_50M);
    set_button(which, 1'b0);
    repeat (8) @(posedge CLK_50M);
  endtask

  task automatic wait_for_audio(input int count, input int limit, output bit ok);
    int cycles;
    cycles = 0;
    while (audio_log.size() < count && cycles < limit)
    begin
      @(posedge CLK_50M);
      cycles++;
    end
    ok = (audio_log.size() >= count);
    if (!ok)
    begin
      $display("Timeout at %0t: only %0d of %0d audio samples arrived",
               $time, audio_log.size(), count);
      error_count++;
    end
  endtask

  task automatic wait_for_reads(input int count, input int limit, output bit ok);
    int cycles;
    cycles = 0;
    while (accepted_addrs.size() < count && cycles < limit)
    begin
      @(posedge CLK_50M);
      cycles++;
    end
    ok = (accepted_addrs.size() >= count);
    if (!ok)
    begin
      $display("Timeout at %0t: only %0d of %0d flash reads were accepted",
               $time, accepted_addrs.size(), count);
      error_count++;
    end
  endtask

  task automatic wait_strobes(input int count, output bit ok);
    int cycles;
    int target;
    int limit;
    cycles = 0;
    target = strobe_times.size() + count;
    limit  = (count + 1) * 2400;
    while (strobe_times.size() < target && cycles < limit)
    begin
      @(posedge CLK_50M);
      cycles++;
    end
    ok = (strobe_times.size() >= target);
    if (!ok)
    begin
      $display("Timeout at %0t: sample strobe stopped firing", $time);
      error_count++;
    end
  endtask

  task automatic check_strobe_gap(input ipod_pkg::div_count_t expected);
    bit     ok;
    longint gap;
    wait_strobes(3, ok);
    if (ok)
    begin
      gap = strobe_times[$] - strobe_times[$ - 1];
      compare_count("sample_strobe spacing", ipod_pkg::div_count_t'(gap), expected);
    end
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic after_reset_test();
    bit ok;
    check_display(ipod_pkg::div_default);
    wait_strobes(3, ok);
    if (accepted_addrs.size() != 0)
    begin
      $display("Flash read was accepted while paused after reset");
      error_count++;
    end
  endtask

  task automatic play_forward_test();
    bit ok_reads;
    bit ok_audio;
    accepted_addrs.delete();
    audio_log.delete();
    send_key(ipod_pkg::scan_play);
    wait_for_reads(3, 20000, ok_reads);
    wait_for_audio(6, 20000, ok_audio);
    if (ok_reads && ok_audio)
    begin
      check_word(0, 23'd0, 1'b0);
      check_word(1, 23'd1, 1'b0);
      check_word(2, 23'd2, 1'b0);
    end
  endtask

  // Restart and direction are set while paused so the start word is known
  task automatic backward_test();
    bit ok_reads;
    bit ok_audio;
    send_key(ipod_pkg::scan_pause);
    send_key(ipod_pkg::scan_restart);
    send_key(ipod_pkg::scan_backward);
    accepted_addrs.delete();
    audio_log.delete();
    send_key(ipod_pkg::scan_play);
    wait_for_reads(3, 20000, ok_reads);
    wait_for_audio(6, 20000, ok_audio);
    if (ok_reads && ok_audio)
    begin
      check_word(0, 23'd0, 1'b1);
      check_word(1, ipod_pkg::audio_last_addr, 1'b1);
      check_word(2, prev_word(ipod_pkg::audio_last_addr), 1'b1);
    end
  endtask

  task automatic pause_break_test();
    bit                    ok;
    int                    reads_before;
    ipod_pkg::flash_addr_t last_addr;
    send_key(ipod_pkg::scan_pause);
    wait_strobes(2, ok);
    reads_before = accepted_addrs.size();
    last_addr    = (reads_before > 0) ? accepted_addrs[$] : '0;
    wait_strobes(3, ok);
    if (accepted_addrs.size() != reads_before)
    begin
      $display("Flash read was accepted after pause");
      error_count++;
    end
    accepted_addrs.delete();
    send_key(ipod_pkg::scan_break);
    send_key(ipod_pkg::scan_play);
    wait_strobes(3, ok);
    if (accepted_addrs.size() != 0)
    begin
      $display("Player resumed on a play code that followed a break prefix");
      error_count++;
    end
    accepted_addrs.delete();
    send_key(ipod_pkg::scan_play);
    wait_for_reads(1, 20000, ok);
    if (ok)
      compare_address("flash_address after resume", accepted_addrs[0], prev_word(last_addr));
  endtask

  task automatic speed_test();
    int expected;
    expected = ipod_pkg::div_default;
    press_button(btn_up);
    expected = expected - ipod_pkg::div_step;
    check_display(ipod_pkg::div_count_t'(expected));
    check_strobe_gap(ipod_pkg::div_count_t'(expected));
    // Walk down to the floor and one step past it
    for (int i = 0; i < 20; i++)
    begin
      press_button(btn_up);
      if (expected - ipod_pkg::div_step < ipod_pkg::div_min)
        expected = ipod_pkg::div_min;
      else
        expected = expected - ipod_pkg::div_step;
      check_display(ipod_pkg::div_count_t'(expected));
    end
    compare_count("div_count floor", DUT.div_count, 16'd272);
    for (int i = 0; i < 2; i++)
    begin
      press_button(btn_down);
      if (expected + ipod_pkg::div_step > ipod_pkg::div_max)
        expected = ipod_pkg::div_max;
      else
        expected = expected + ipod_pkg::div_step;
      check_display(ipod_pkg::div_count_t'(expected));
    end
    press_button(btn_reset);
    check_display(16'd2272);
    check_strobe_gap(16'd2272);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial
  begin
    rst                 = 1'b1;
    ps2_clk             = 1'b1;
    ps2_data            = 1'b1;
    speed_up            = 1'b0;
    speed_down          = 1'b0;
    speed_reset         = 1'b0;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    repeat (8) @(posedge CLK_50M);
    rst <= 1'b0;
    @(posedge CLK_50M);

    after_reset_test();
    play_forward_test();
    backward_test();
    pause_break_test();
    speed_test();

    $display("Check errors: %0d, assertion failures: %0d",
             error_count, DUT.u_player.u_checker.assert_errors);
    if (error_count == 0 && DUT.u_player.u_checker.assert_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
